// File: include/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// pixel and weight width
`define CONV_PIX_W    8

// pixels in one image row
`define CONV_ROW_PIX  8

// kernel side, square window
`define CONV_K        3

// output columns per row, no padding
`define CONV_LANES    6

// nine 16-bit products fit in 20 bits
`define CONV_ACC_W    20

`endif

// File: src/conv_pkg.sv
`include "conv_config.svh"

package conv_pkg;

	typedef logic [`CONV_PIX_W-1:0]                    pixel_t;
	typedef logic [`CONV_PIX_W-1:0]                    weight_t;
	typedef logic [2*`CONV_PIX_W-1:0]                  product_t;
	typedef logic [`CONV_ACC_W-1:0]                    acc_t;
	typedef logic [`CONV_ROW_PIX*`CONV_PIX_W-1:0]      row_t;     // pixel p in byte p
	typedef logic [`CONV_K*`CONV_K*`CONV_PIX_W-1:0]    window_t;  // index r*3+c, row 0 oldest
	typedef logic [`CONV_K*`CONV_K*`CONV_PIX_W-1:0]    kernel_t;

	typedef enum logic [1:0] {
		END   = 2'd0,
		START = 2'd1,
		HOLD  = 2'd2
	} ctrl_cmd_e;

	typedef enum logic [1:0] {
		FINISH  = 2'd1,
		WAIT    = 2'd2,
		COMPUTE = 2'd3
	} conv_state_e;

	// col[j] is output column j
	typedef struct packed {
		acc_t [`CONV_LANES-1:0] col;
	} conv_result_t;

endpackage

// File: src/conv_ctrl.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_ctrl import conv_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  ctrl_cmd_e i_ctrl,
	output logic      o_wait,
	output logic      o_compute,
	output logic      o_hold,
	output logic      o_finish
);

	conv_state_e state_q;
	conv_state_e state_d;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q <= WAIT;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			WAIT: begin
				if (i_ctrl == START) begin
					state_d = COMPUTE;
				end else if (i_ctrl == END) begin
					state_d = FINISH;
				end
			end
			COMPUTE: begin
				if (i_ctrl == HOLD) begin
					state_d = WAIT;
				end else if (i_ctrl == END) begin
					state_d = FINISH;
				end
			end
			FINISH: begin
				state_d = FINISH; // left only by reset
			end
			default: begin
				state_d = WAIT;
			end
		endcase
	end

	assign o_wait    = (state_q == WAIT);
	assign o_compute = (state_q == COMPUTE);
	assign o_finish  = (state_q == FINISH);

	// buffers restart their counts on this edge
	assign o_hold = (state_q == COMPUTE) && (i_ctrl == HOLD);

endmodule

// File: src/weight_buffer.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module weight_buffer import conv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    i_wait,
	input  logic    i_hold,
	input  logic    i_w_valid,
	input  row_t    i_w_data,
	output kernel_t o_kernel
);

	logic [1:0] beat_q;
	kernel_t    kernel_q;
	logic       take;

	// two beats per kernel, extra beats dropped
	assign take = i_w_valid && i_wait && (beat_q < 2'd2);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			beat_q   <= '0;
			kernel_q <= '0;
		end else begin
			if (i_hold) begin
				beat_q <= '0;
			end else if (take) begin
				beat_q <= beat_q + 2'd1;
			end

			if (take) begin
				if (beat_q == 2'd0) begin
					// weights 0..7, byte b is weight b
					kernel_q[`CONV_ROW_PIX*`CONV_PIX_W-1:0] <= i_w_data;
				end else begin
					// last weight from byte 0
					kernel_q[`CONV_K*`CONV_K*`CONV_PIX_W-1 -: `CONV_PIX_W] <=
						weight_t'(i_w_data);
				end
			end
		end
	end

	assign o_kernel = kernel_q;

endmodule

// File: src/line_buffer.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module line_buffer import conv_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_compute,
	input  logic               i_finish,
	input  logic               i_hold,
	input  logic               i_valid,
	input  row_t               i_data,
	output row_t [`CONV_K-1:0] o_window_rows,
	output logic               o_win_strobe
);

	row_t [`CONV_K-1:0] rows_q;   // index 0 oldest
	logic [1:0]         cnt_q;
	logic               accept;
	logic               full_win;

	assign accept = i_valid && !i_finish;

	// enough older rows for this one to close a window
	assign full_win = (cnt_q >= 2'(`CONV_K - 1));

	always_ff @(posedge clk) begin
		if (accept) begin
			rows_q <= {i_data, rows_q[`CONV_K-1:1]};
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt_q        <= '0;
			o_win_strobe <= 1'b0;
		end else begin
			o_win_strobe <= accept && i_compute && full_win;

			if (i_hold) begin
				cnt_q <= '0;
			end else if (accept && (cnt_q != 2'd3)) begin
				cnt_q <= cnt_q + 2'd1; // saturates
			end
		end
	end

	assign o_window_rows = rows_q;

endmodule

// File: src/conv_lane.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_lane import conv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  window_t i_window,
	input  kernel_t i_kernel,
	output acc_t    o_sum
);

	localparam int TAPS = `CONV_K * `CONV_K;

	pixel_t   px     [TAPS];
	weight_t  wt     [TAPS];
	product_t prod_q [TAPS];
	acc_t     row_sum [`CONV_K];
	acc_t     sum_d;
	acc_t     sum_q;

	always_comb begin
		for (int t = 0; t < TAPS; t++) begin
			px[t] = i_window[t*`CONV_PIX_W +: `CONV_PIX_W];
			wt[t] = i_kernel[t*`CONV_PIX_W +: `CONV_PIX_W];
		end
	end

	// stage 1, nine multipliers
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int t = 0; t < TAPS; t++) begin
				prod_q[t] <= '0;
			end
		end else begin
			for (int t = 0; t < TAPS; t++) begin
				prod_q[t] <= px[t] * wt[t];
			end
		end
	end

	// per-row partial sums, then total
	always_comb begin
		sum_d = '0;
		for (int r = 0; r < `CONV_K; r++) begin
			row_sum[r] = '0;
			for (int c = 0; c < `CONV_K; c++) begin
				row_sum[r] = row_sum[r] + acc_t'(prod_q[r*`CONV_K+c]);
			end
			sum_d = sum_d + row_sum[r];
		end
	end

	// stage 2
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sum_q <= '0;
		end else begin
			sum_q <= sum_d;
		end
	end

	assign o_sum = sum_q;

endmodule

// File: src/conv_array.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_array import conv_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  row_t [`CONV_K-1:0] i_window_rows,
	input  logic               i_win_strobe,
	input  kernel_t            i_kernel,
	output conv_result_t       o_result,
	output logic               o_res_valid
);

	localparam int PW = `CONV_PIX_W;

	acc_t [`CONV_LANES-1:0] sums;
	logic [1:0]             vld_q;   // matches the two lane stages

	for (genvar j = 0; j < `CONV_LANES; j++) begin : g_lane
		window_t win;

		// pixels j..j+2 of each row
		always_comb begin
			for (int r = 0; r < `CONV_K; r++) begin
				for (int c = 0; c < `CONV_K; c++) begin
					win[(r*`CONV_K+c)*PW +: PW] = i_window_rows[r][(j+c)*PW +: PW];
				end
			end
		end

		conv_lane u_lane (
			.clk      (clk),
			.rst      (rst),
			.i_window (win),
			.i_kernel (i_kernel),
			.o_sum    (sums[j])
		);
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[0], i_win_strobe};
		end
	end

	assign o_result.col = sums;
	assign o_res_valid  = vld_q[1];

endmodule

// File: src/conv_top.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_top import conv_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  ctrl_cmd_e    i_ctrl,
	input  logic         i_valid,
	input  row_t         i_data,
	input  logic         i_w_valid,
	input  row_t         i_w_data,
	output conv_result_t o_result,
	output logic         o_res_valid,
	output logic         o_finish
);

	logic               wait_lvl;
	logic               compute_lvl;
	logic               hold_pulse;
	kernel_t            kernel;
	row_t [`CONV_K-1:0] window_rows;
	logic               win_strobe;

	conv_ctrl u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.i_ctrl    (i_ctrl),
		.o_wait    (wait_lvl),
		.o_compute (compute_lvl),
		.o_hold    (hold_pulse),
		.o_finish  (o_finish)
	);

	weight_buffer u_wbuf (
		.clk       (clk),
		.rst       (rst),
		.i_wait    (wait_lvl),
		.i_hold    (hold_pulse),
		.i_w_valid (i_w_valid),
		.i_w_data  (i_w_data),
		.o_kernel  (kernel)
	);

	line_buffer u_lbuf (
		.clk           (clk),
		.rst           (rst),
		.i_compute     (compute_lvl),
		.i_finish      (o_finish),
		.i_hold        (hold_pulse),
		.i_valid       (i_valid),
		.i_data        (i_data),
		.o_window_rows (window_rows),
		.o_win_strobe  (win_strobe)
	);

	conv_array u_array (
		.clk           (clk),
		.rst           (rst),
		.i_window_rows (window_rows),
		.i_win_strobe  (win_strobe),
		.i_kernel      (kernel),
		.o_result      (o_result),
		.o_res_valid   (o_res_valid)
	);

endmodule

// File: sim/conv_chk.sv
`timescale 1ns/100ps

module conv_chk (
	input logic clk,
	input logic rst,
	input logic i_finish,
	input logic i_res_valid
);

	int unsigned fails = 0;   // failed assertion count

	a_finish_sticky: assert property (
		@(posedge clk) disable iff (!rst) i_finish |=> i_finish
	) else begin
		$error("o_finish fell without a reset");
		fails++;
	end

	// rows taken up to the END edge drain within three cycles
	a_no_late_result: assert property (
		@(posedge clk) disable iff (!rst) (i_finish && $past(i_finish, 3)) |-> !i_res_valid
	) else begin
		$error("o_res_valid high long after entering FINISH");
		fails++;
	end

	a_reset_clean: assert property (
		@(posedge clk) $rose(rst) |-> (!i_res_valid && !i_finish)
	) else begin
		$error("outputs not low in first cycle after reset");
		fails++;
	end

endmodule

bind conv_top conv_chk u_chk (
	.clk         (clk),
	.rst         (rst),
	.i_finish    (o_finish),
	.i_res_valid (o_res_valid)
);

// File: sim/tb_conv.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module tb_conv import conv_pkg::*; ();

	localparam string STIM_FILE = "sim/conv_stim.txt";

	typedef enum logic [2:0] {
		OP_RESET, OP_CTRL, OP_WEIGHT, OP_ROW, OP_IDLE, OP_EXPECT
	} stim_op_e;

	typedef struct packed {
		stim_op_e     op;
		ctrl_cmd_e    cmd;
		row_t         data;
		logic [31:0]  count;
		logic         has_exp;
		conv_result_t exp;
	} stim_rec_t;

	typedef struct packed {
		conv_result_t res;
		logic [31:0]  due;   // cycle with o_res_valid high
	} pending_t;

	logic         clk;
	logic         rst;
	ctrl_cmd_e    i_ctrl;
	logic         i_valid;
	row_t         i_data;
	logic         i_w_valid;
	row_t         i_w_data;
	conv_result_t o_result;
	logic         o_res_valid;
	logic         o_finish;

	stim_rec_t    recs[$];
	pending_t     pending[$];
	pending_t     head;
	logic [31:0]  cyc;
	logic [31:0]  last_row_cyc;
	logic         exp_finish;
	longint       wd_limit;

	conv_top DUT (
		.clk         (clk),
		.rst         (rst),
		.i_ctrl      (i_ctrl),
		.i_valid     (i_valid),
		.i_data      (i_data),
		.i_w_valid   (i_w_valid),
		.i_w_data    (i_w_data),
		.o_result    (o_result),
		.o_res_valid (o_res_valid),
		.o_finish    (o_finish)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 32'd1;
	end

	task automatic fail_now();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %0t ns: %s expected %b, actual %b", $time, name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_result(input conv_result_t exp, input conv_result_t act);
		for (int j = 0; j < `CONV_LANES; j++) begin
			if (act.col[j] !== exp.col[j]) begin
				$display("[ERROR] %0t ns: o_result.col[%0d] expected %0d, actual %0d",
					$time, j, exp.col[j], act.col[j]);
				fail_now();
			end
		end
	endtask

	task automatic read_stim();
		int        fd;
		int        ch;
		int        v;
		int        ok;
		string     tok;
		string     arg;
		row_t      d;
		stim_rec_t rec;

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("could not open stimulus file %s", STIM_FILE);
			fail_now();
		end
		ok = 1;
		while ($fscanf(fd, "%s", tok) == 1) begin
			rec = '0;
			if (tok.getc(0) == "#") begin
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1) begin
					ch = $fgetc(fd);
				end
				continue;
			end
			if (tok == "reset") begin
				rec.op = OP_RESET;
			end else if (tok == "ctrl") begin
				rec.op = OP_CTRL;
				ok &= ($fscanf(fd, "%s", arg) == 1);
				if (arg == "START") begin
					rec.cmd = START;
				end else if (arg == "HOLD") begin
					rec.cmd = HOLD;
				end else begin
					rec.cmd = END;
					ok &= (arg == "END");
				end
			end else if (tok == "weight" || tok == "row") begin
				rec.op = (tok == "row") ? OP_ROW : OP_WEIGHT;
				ok &= ($fscanf(fd, "%h", d) == 1);
				rec.data = d;
			end else if (tok == "idle") begin
				rec.op = OP_IDLE;
				ok &= ($fscanf(fd, "%d", v) == 1);
				rec.count = v;
			end else if (tok == "expect") begin
				rec.op = OP_EXPECT;
				ok &= ($fscanf(fd, "%s", arg) == 1);
				if (arg != "none") begin
					rec.has_exp = 1'b1;
					ok &= ($sscanf(arg, "%d", v) == 1);
					rec.exp.col[0] = acc_t'(v);
					for (int j = 1; j < `CONV_LANES; j++) begin
						ok &= ($fscanf(fd, "%d", v) == 1);
						rec.exp.col[j] = acc_t'(v);
					end
				end
			end else begin
				ok = 0;
			end
			if (!ok) begin
				$display("malformed record '%s' in %s", tok, STIM_FILE);
				fail_now();
			end
			recs.push_back(rec);
		end
		$fclose(fd);
	endtask

	// strobes last one cycle
	task automatic next_cycle();
		@(posedge clk);
		#1;
		i_valid   = 1'b0;
		i_w_valid = 1'b0;
	endtask

	task automatic run_stim();
		logic     prev_row;
		pending_t p;

		prev_row = 1'b0;
		foreach (recs[i]) begin
			case (recs[i].op)
				OP_RESET: begin
					rst = 1'b0;
					repeat (4) @(posedge clk);
					#1;
					rst = 1'b1;
					@(negedge clk);
					check_flag("o_res_valid", 1'b0, o_res_valid);
					check_flag("o_finish", 1'b0, o_finish);
				end
				OP_CTRL: begin
					next_cycle();
					i_ctrl = recs[i].cmd;   // level stays until the next command
					if (recs[i].cmd == END) begin
						exp_finish = 1'b1;
					end
				end
				OP_WEIGHT: begin
					next_cycle();
					i_w_valid = 1'b1;
					i_w_data  = recs[i].data;
				end
				OP_ROW: begin
					if (prev_row) begin
						repeat ($urandom_range(2, 0)) next_cycle();
					end
					next_cycle();
					i_valid      = 1'b1;
					i_data       = recs[i].data;
					last_row_cyc = cyc;
				end
				OP_IDLE: begin
					repeat (recs[i].count) next_cycle();
				end
				OP_EXPECT: begin
					if (recs[i].has_exp) begin
						p.res = recs[i].exp;
						p.due = last_row_cyc + 32'd3;   // accept edge plus two
						pending.push_back(p);
					end
				end
				default: begin
				end
			endcase
			if (recs[i].op != OP_EXPECT) begin
				prev_row = (recs[i].op == OP_ROW);
			end
		end
		next_cycle();
	endtask

	always @(negedge clk) begin
		if (DUT.u_chk.fails != 0) begin
			$display("an assertion in conv_chk failed");
			fail_now();
		end
		if (o_res_valid) begin
			if (pending.size() == 0 || pending[0].due != cyc) begin
				check_flag("o_res_valid", 1'b0, o_res_valid);
			end
			head = pending.pop_front();
			check_result(head.res, o_result);
		end else if (pending.size() != 0 && pending[0].due == cyc) begin
			check_flag("o_res_valid", 1'b1, o_res_valid);
		end
	end

	initial begin
		wait (wd_limit != 0);
		#(wd_limit);
		$display("watchdog expired after %0d ns, stimulus did not complete", wd_limit);
		fail_now();
	end

	initial begin
		rst          = 1'b0;
		i_ctrl       = HOLD;   // no effect in WAIT
		i_valid      = 1'b0;
		i_data       = '0;
		i_w_valid    = 1'b0;
		i_w_data     = '0;
		cyc          = '0;
		last_row_cyc = '0;
		exp_finish   = 1'b0;
		void'($urandom(32'h1d68285d));
		read_stim();
		wd_limit = (recs.size() + 20) * 10 * 2;
		run_stim();
		repeat (4) next_cycle();   // drain pipeline
		check_flag("o_finish", exp_finish, o_finish);
		if (pending.size() != 0) begin
			$display("%0d expected results never appeared on o_result", pending.size());
			fail_now();
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

// File: sim/conv_stim.txt
# records: reset | ctrl START/HOLD/END | weight <hex64> | row <hex64> | idle <cycles>
# expect <col0..col5 decimal> or expect none, for the row just before it
reset
idle 2
# kernel 1..9
weight 0807060504030201
weight aabbccddeeff1109
idle 1
ctrl START
row 0807060504030201
expect none
row 1716151413121110
expect none
row 2e2c2a2826242220
expect 1091 1160 1229 1298 1367 1436
row c8c8c8c8c8c8c8c8
expect 5418 5454 5490 5526 5562 5598
# beat in COMPUTE is dropped
weight ffffffffffffffff
row f8f9fafbfcfdfeff
expect 9302 9290 9278 9266 9254 9242
row 463c32281e140a00
expect 5268 5493 5718 5943 6168 6393
row 6464646464646464
expect 4092 4236 4380 4524 4668 4812
ctrl HOLD
# kernel 2 0 1 0 3 0 1 0 2, third beat dropped
weight 0001000300010002
weight 5500000000000002
weight 0000000000000077
ctrl START
row 463c32281e140a00
expect none
row 0807060504030201
expect none
row 2e2c2a2826242220
expect 130 169 208 247 286 325
row f8f9fafbfcfdfeff
expect 868 874 880 886 892 898
ctrl END
idle 2
row 6464646464646464
expect none
row c8c8c8c8c8c8c8c8
expect none
idle 4

// File: compile.f
+incdir+include
src/conv_pkg.sv
src/conv_ctrl.sv
src/weight_buffer.sv
src/line_buffer.sv
src/conv_lane.sv
src/conv_array.sv
src/conv_top.sv
sim/conv_chk.sv
sim/tb_conv.sv

// File: Bender.yml
package:
  name: conv_engine

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/conv_pkg.sv
      - src/conv_ctrl.sv
      - src/weight_buffer.sv
      - src/line_buffer.sv
      - src/conv_lane.sv
      - src/conv_array.sv
      - src/conv_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/conv_chk.sv
      - sim/tb_conv.sv
